/* rv_core_pkg.sv */
/*
 * Widths, encodings and pipeline records of the RV32I integer core.
 * Every RTL module of the core imports what it needs from here.
 */
`default_nettype none

package rv_core_pkg;

	// ==================================================
	// Widths
	// ==================================================
	localparam int XLEN   = 32;
	localparam int N_REGS = 32;
	localparam int REG_AW = $clog2(N_REGS);

	typedef logic [XLEN-1:0]   data_t;
	typedef logic [REG_AW-1:0] reg_addr_t;
	typedef logic [31:0]       instr_t;

	// ==================================================
	// Instruction encodings
	// ==================================================

	// Major opcodes that the core executes
	typedef enum logic [6:0] {
		OPC_OP     = 7'b0110011,
		OPC_OP_IMM = 7'b0010011,
		OPC_LUI    = 7'b0110111
	} opcode_e;

	// funct3 field of OP and OP-IMM
	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;

	// funct7 field, alternate form selects SUB and SRA
	localparam logic [6:0] F7_BASE = 7'b0000000;
	localparam logic [6:0] F7_ALT  = 7'b0100000;

	// ==================================================
	// Execute controls
	// ==================================================
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND
	} alu_op_e;

	typedef enum logic {SRCA_RS1, SRCA_ZERO} src_a_e;
	typedef enum logic {SRCB_RS2, SRCB_IMM} src_b_e;

	// Decode to execute record
	typedef struct packed {
		logic      valid;
		logic      illegal;
		reg_addr_t rd;
		reg_addr_t rs1;
		reg_addr_t rs2;
		alu_op_e   alu_op;
		src_a_e    src_a;
		src_b_e    src_b;
		data_t     imm;
	} dec_ctrl_t;

	// Writeback record
	typedef struct packed {
		logic      valid;
		logic      illegal;
		reg_addr_t rd;
		data_t     result;
	} wb_t;

endpackage

`default_nettype wire

/* rv_alu.sv */
/*
 * Combinational integer ALU for the ten RV32I register operations.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_alu (
	input  wire rv_core_pkg::alu_op_e alu_op_i,
	input  wire rv_core_pkg::data_t   op_a_i,
	input  wire rv_core_pkg::data_t   op_b_i,
	output rv_core_pkg::data_t        result_o
);

	import rv_core_pkg::*;

	logic [4:0] shamt;
	logic       lt_signed;
	logic       lt_unsigned;

	// Shift amount from the low bits only
	assign shamt = op_b_i[4:0];

	assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
	assign lt_unsigned = op_a_i < op_b_i;

	always_comb begin
		case (alu_op_i)
			ALU_ADD:  result_o = op_a_i + op_b_i;
			ALU_SUB:  result_o = op_a_i - op_b_i;
			ALU_SLL:  result_o = op_a_i << shamt;
			ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
			ALU_XOR:  result_o = op_a_i ^ op_b_i;
			ALU_SRL:  result_o = op_a_i >> shamt;
			ALU_SRA:  result_o = data_t'($signed(op_a_i) >>> shamt);
			ALU_OR:   result_o = op_a_i | op_b_i;
			ALU_AND:  result_o = op_a_i & op_b_i;
			default:  result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rv_regfile.sv */
/*
 * Integer register file, two synchronous read ports and one write port.
 * No write-to-read bypass; the execute stage covers that case.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire rv_core_pkg::reg_addr_t raddr1_i,
	input  wire rv_core_pkg::reg_addr_t raddr2_i,
	output rv_core_pkg::data_t          rdata1_o,
	output rv_core_pkg::data_t          rdata2_o,
	input  wire rv_core_pkg::reg_addr_t waddr_i,
	input  wire rv_core_pkg::data_t     wdata_i,
	input  wire logic                  wen_i
);

	import rv_core_pkg::*;

	data_t regs [N_REGS];

	// ==================================================
	// Storage
	// ==================================================

	// x0 is never written, so it reads zero forever
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < N_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Read ports, one cycle from address to data
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rdata1_o <= '0;
			rdata2_o <= '0;
		end else begin
			rdata1_o <= regs[raddr1_i];
			rdata2_o <= regs[raddr2_i];
		end
	end

	// Execute stage qualifies the write enable with rd
	assert property (@(posedge clk) disable iff (!rst_n)
		!(wen_i && waddr_i == '0));

endmodule

`default_nettype wire

/* rv_decoder.sv */
/*
 * Stage D decoder. Turns one instruction word per cycle into registered
 * execute controls and immediate; anything outside the kept set is illegal.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_decoder (
	input  wire logic                  clk,
	input  wire logic                  rst_n,
	input  wire rv_core_pkg::instr_t   instr_i,
	input  wire logic                  instr_vld_i,
	output rv_core_pkg::dec_ctrl_t     dx_ctrl_o
);

	import rv_core_pkg::*;

	opcode_e    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	data_t      imm_i;
	data_t      imm_u;
	logic       op_f7_ok;
	logic       imm_f7_ok;
	dec_ctrl_t  ctrl_d;

	// Shared between OP and OP-IMM, alt picks SUB or SRA
	function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
			F3_SLL:     op = ALU_SLL;
			F3_SLT:     op = ALU_SLT;
			F3_SLTU:    op = ALU_SLTU;
			F3_XOR:     op = ALU_XOR;
			F3_SRL_SRA: op = alt ? ALU_SRA : ALU_SRL;
			F3_OR:      op = ALU_OR;
			default:    op = ALU_AND;
		endcase
		return op;
	endfunction

	assign opcode = opcode_e'(instr_i[6:0]);
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	// I and U immediates
	assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_u = {instr_i[31:12], 12'h000};

	// Register form: alternate funct7 only for ADD/SUB and SRL/SRA
	assign op_f7_ok = (funct7 == F7_BASE) ||
		(funct7 == F7_ALT && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));

	// Immediate shifts carry funct7 in the upper immediate bits
	always_comb begin
		case (funct3)
			F3_SLL:     imm_f7_ok = (funct7 == F7_BASE);
			F3_SRL_SRA: imm_f7_ok = (funct7 == F7_BASE) || (funct7 == F7_ALT);
			default:    imm_f7_ok = 1'b1;
		endcase
	end

	always_comb begin
		ctrl_d.valid   = instr_vld_i;
		ctrl_d.illegal = 1'b0;
		ctrl_d.rd      = instr_i[11:7];
		ctrl_d.rs1     = instr_i[19:15];
		ctrl_d.rs2     = instr_i[24:20];
		ctrl_d.alu_op  = ALU_ADD;
		ctrl_d.src_a   = SRCA_RS1;
		ctrl_d.src_b   = SRCB_RS2;
		ctrl_d.imm     = imm_i;

		case (opcode)
			OPC_OP: begin
				ctrl_d.alu_op  = f3_to_alu(funct3, instr_i[30]);
				ctrl_d.illegal = !op_f7_ok;
			end
			OPC_OP_IMM: begin
				// Bit 30 is an immediate bit except for SRAI
				ctrl_d.alu_op  = f3_to_alu(funct3, funct3 == F3_SRL_SRA && instr_i[30]);
				ctrl_d.src_b   = SRCB_IMM;
				ctrl_d.illegal = !imm_f7_ok;
			end
			OPC_LUI: begin
				ctrl_d.src_a = SRCA_ZERO;
				ctrl_d.src_b = SRCB_IMM;
				ctrl_d.imm   = imm_u;
			end
			default: begin
				ctrl_d.illegal = 1'b1;
			end
		endcase

		if (ctrl_d.illegal) begin
			ctrl_d.rd = '0;
		end

		// Bubble: cleared register fields keep the bypass from matching
		if (!instr_vld_i) begin
			ctrl_d.illegal = 1'b0;
			ctrl_d.rd      = '0;
			ctrl_d.rs1     = '0;
			ctrl_d.rs2     = '0;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx_ctrl_o <= '0;
		end else begin
			dx_ctrl_o <= ctrl_d;
		end
	end

	// Illegal records must never reach the register file write port
	assert property (@(posedge clk) disable iff (!rst_n)
		dx_ctrl_o.illegal |-> dx_ctrl_o.rd == '0);

endmodule

`default_nettype wire

/* rv_execute.sv */
/*
 * Stage X. Resolves operands through the bypass, runs the ALU and
 * registers the writeback record, which also drives the register file write.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire rv_core_pkg::dec_ctrl_t dx_ctrl_i,
	input  wire rv_core_pkg::data_t     rdata1_i,
	input  wire rv_core_pkg::data_t     rdata2_i,
	output rv_core_pkg::wb_t            wb_o,
	output rv_core_pkg::reg_addr_t      rf_waddr_o,
	output rv_core_pkg::data_t          rf_wdata_o,
	output logic                        rf_wen_o
);

	import rv_core_pkg::*;

	// Record being written to the register file one edge ago
	wb_t   wb_prev;
	wb_t   wb_d;
	data_t rs1_val;
	data_t rs2_val;
	data_t op_a;
	data_t op_b;
	data_t alu_result;

	// Priority order is x0, newest writeback, previous writeback, register file
	function automatic data_t bypass(input reg_addr_t rs, input data_t rf_data,
		input wb_t last, input wb_t prev);
		data_t val;
		if (rs == '0) begin
			val = '0;
		end else if (last.rd == rs) begin
			val = last.result;
		end else if (prev.rd == rs) begin
			val = prev.result;
		end else begin
			val = rf_data;
		end
		return val;
	endfunction

	// ==================================================
	// Operand select
	// ==================================================
	assign rs1_val = bypass(dx_ctrl_i.rs1, rdata1_i, wb_o, wb_prev);
	assign rs2_val = bypass(dx_ctrl_i.rs2, rdata2_i, wb_o, wb_prev);

	assign op_a = (dx_ctrl_i.src_a == SRCA_ZERO) ? '0 : rs1_val;
	assign op_b = (dx_ctrl_i.src_b == SRCB_IMM) ? dx_ctrl_i.imm : rs2_val;

	rv_alu i_rv_alu (
		.alu_op_i (dx_ctrl_i.alu_op),
		.op_a_i   (op_a),
		.op_b_i   (op_b),
		.result_o (alu_result)
	);

	// ==================================================
	// Writeback
	// ==================================================
	assign wb_d.valid   = dx_ctrl_i.valid;
	assign wb_d.illegal = dx_ctrl_i.illegal;
	assign wb_d.rd      = dx_ctrl_i.rd;
	assign wb_d.result  = (dx_ctrl_i.illegal || !dx_ctrl_i.valid) ? '0 : alu_result;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_o    <= '0;
			wb_prev <= '0;
		end else begin
			wb_o    <= wb_d;
			wb_prev <= wb_o;
		end
	end

	assign rf_waddr_o = wb_o.rd;
	assign rf_wdata_o = wb_o.result;
	assign rf_wen_o   = wb_o.valid && !wb_o.illegal && (wb_o.rd != '0);

	// An illegal record carries no data
	assert property (@(posedge clk) disable iff (!rst_n)
		wb_o.illegal |-> wb_o.result == '0);

endmodule

`default_nettype wire

/* rv_core.sv */
/*
 * Top level of the integer core. Decoder and register file work side by
 * side in stage D, execute follows; results leave on the writeback port.
 */
`timescale 1ns/1ps
`default_nettype none

module rv_core (
	input  wire logic                clk,
	input  wire logic                rst_n,
	input  wire rv_core_pkg::instr_t instr_i,
	input  wire logic                instr_vld_i,
	output rv_core_pkg::wb_t         wb_o
);

	import rv_core_pkg::*;

	dec_ctrl_t dx_ctrl;
	data_t     dx_rdata1;
	data_t     dx_rdata2;
	reg_addr_t rf_waddr;
	data_t     rf_wdata;
	logic      rf_wen;

	// ==================================================
	// Stage D
	// ==================================================
	rv_decoder i_rv_decoder (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_i     (instr_i),
		.instr_vld_i (instr_vld_i),
		.dx_ctrl_o   (dx_ctrl)
	);

	// Read addresses straight from the rs1 and rs2 fields
	rv_regfile i_rv_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.raddr1_i (instr_i[19:15]),
		.raddr2_i (instr_i[24:20]),
		.rdata1_o (dx_rdata1),
		.rdata2_o (dx_rdata2),
		.waddr_i  (rf_waddr),
		.wdata_i  (rf_wdata),
		.wen_i    (rf_wen)
	);

	// ==================================================
	// Stage X
	// ==================================================
	rv_execute i_rv_execute (
		.clk        (clk),
		.rst_n      (rst_n),
		.dx_ctrl_i  (dx_ctrl),
		.rdata1_i   (dx_rdata1),
		.rdata2_i   (dx_rdata2),
		.wb_o       (wb_o),
		.rf_waddr_o (rf_waddr),
		.rf_wdata_o (rf_wdata),
		.rf_wen_o   (rf_wen)
	);

endmodule

`default_nettype wire

/* tb_rv_model.svh */
/*
 * Random instruction source and expected-result model for the core testbench.
 * Included inside the testbench module, after the package import.
 */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

logic [31:0] rng_state;
data_t       model_regs [N_REGS];
reg_addr_t   recent_rd [4];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
	logic [31:0] y;
	y = x ^ (x << 13);
	y = y ^ (y >> 17);
	return y ^ (y << 5);
endfunction

task automatic next_rand(output logic [31:0] r);
	rng_state = xorshift32(rng_state);
	r = rng_state;
endtask

// Few registers, sources often taken from the last four destinations
task automatic gen_instr(output instr_t ins);
	logic [31:0] r;
	logic [31:0] k;
	reg_addr_t   rd;
	reg_addr_t   rs1;
	reg_addr_t   rs2;
	logic [2:0]  f3;
	logic [6:0]  f7;
	next_rand(r);
	next_rand(k);
	rd  = k[3] ? k[8:4] : {2'b00, k[6:4]};
	rs1 = r[0] ? recent_rd[r[2:1]] : {2'b00, k[11:9]};
	rs2 = r[3] ? recent_rd[r[5:4]] : {2'b00, k[14:12]};
	f3  = r[11:9];
	f7  = (r[16] && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00;
	if (r[15:12] <= 4'd5)
		ins = {f7, rs2, rs1, f3, rd, 7'h33};
	else if (r[15:12] <= 4'd11 && (f3 == 3'd1 || f3 == 3'd5))
		ins = {f7, k[24:20], rs1, f3, rd, 7'h13};
	else if (r[15:12] <= 4'd11)
		ins = {k[31:20], rs1, f3, rd, 7'h13};
	else if (r[15:12] == 4'd12)
		ins = {k[31:12], rd, 7'h37};
	else if (r[15:12] == 4'd15)
		ins = {7'h01 | r[22:16], rs2, rs1, f3, rd, 7'h33};
	else
		ins = k;
	for (int i = 3; i > 0; i--)
		recent_rd[i] = recent_rd[i - 1];
	recent_rd[0] = rd;
endtask

// RV32I semantics on the model registers, x0 stays zero
function automatic wb_t predict_wb(input instr_t ins);
	wb_t        res;
	data_t      a;
	data_t      b;
	logic [2:0] f3;
	logic [6:0] f7;
	logic       alt;
	logic       legal;
	f3    = ins[14:12];
	f7    = ins[31:25];
	a     = model_regs[ins[19:15]];
	b     = model_regs[ins[24:20]];
	res   = '0;
	alt   = 1'b0;
	legal = 1'b1;
	case (ins[6:0])
		7'h33: begin
			legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
			alt   = f7[5];
		end
		7'h13: begin
			b     = {{20{ins[31]}}, ins[31:20]};
			legal = (f3 == 3'd1) ? (f7 == 7'h00) :
				(f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
			alt   = (f3 == 3'd5) && f7[5];
		end
		7'h37: begin
			a  = '0;
			b  = {ins[31:12], 12'h000};
			f3 = 3'd0;
		end
		default: legal = 1'b0;
	endcase
	res.valid   = 1'b1;
	res.illegal = !legal;
	if (legal) begin
		case (f3)
			3'd0: res.result = alt ? a - b : a + b;
			3'd1: res.result = a << b[4:0];
			3'd2: res.result = {31'b0, $signed(a) < $signed(b)};
			3'd3: res.result = {31'b0, a < b};
			3'd4: res.result = a ^ b;
			3'd5: res.result = alt ? data_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6: res.result = a | b;
			3'd7: res.result = a & b;
		endcase
		res.rd = ins[11:7];
		if (res.rd != '0)
			model_regs[res.rd] = res.result;
	end
	return res;
endfunction

`endif

/* tb_rv_core.sv */
/*
 * Testbench for the integer core. Drives random and directed instructions with
 * idle gaps and checks every writeback record two cycles after its instruction.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core;

	import rv_core_pkg::*;

	localparam int N_INSTR    = 2000;
	localparam int MAX_CYCLES = N_INSTR * 2 + 100;
	localparam int DRIVE_DLY  = 1;

	logic       clk;
	logic       rst_n;
	instr_t     instr;
	logic       instr_vld;
	wb_t        wb;
	wb_t        exp_q [$];
	logic [1:0] vld_hist;
	int         cycle_cnt;
	int         n_sent;
	int         n_checked;

	`include "tb_rv_model.svh"

	rv_core i_rv_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_i     (instr),
		.instr_vld_i (instr_vld),
		.wb_o        (wb)
	);

	always #4 clk = ~clk;

	task automatic report_failure();
		$display("Test FAILED");
		$fatal(1, "Simulation stopped on first failure");
	endtask

	// ==================================================
	// Stimulus
	// ==================================================
	task automatic drive_instr(input instr_t ins);
		@(posedge clk);
		#(DRIVE_DLY);
		instr     = ins;
		instr_vld = 1'b1;
		exp_q.push_back(predict_wb(ins));
		n_sent++;
	endtask

	// Junk on instr_i while idle must not disturb the pipeline
	task automatic drive_idle();
		logic [31:0] r;
		next_rand(r);
		@(posedge clk);
		#(DRIVE_DLY);
		instr     = r;
		instr_vld = 1'b0;
	endtask

	// ==================================================
	// Checks
	// ==================================================
	task automatic check_wb(input wb_t got, input wb_t exp);
		if (got !== exp) begin
			$display("Error at %0t: wb_o valid=%0b illegal=%0b rd=%0d result=%h",
				$time, got.valid, got.illegal, got.rd, got.result);
			$display("  expected valid=%0b illegal=%0b rd=%0d result=%h",
				exp.valid, exp.illegal, exp.rd, exp.result);
			report_failure();
		end
	endtask

	task automatic check_idle(input wb_t got);
		if (got.valid !== 1'b0) begin
			$display("Unexpected writeback on wb_o at %0t with no instruction two cycles earlier",
				$time);
			report_failure();
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk) begin : compare_wb
		wb_t exp_rec;
		if (!rst_n) begin
			vld_hist = '0;
		end else begin
			if (!vld_hist[1]) begin
				check_idle(wb);
			end else if (wb.valid !== 1'b1) begin
				$display("Missing writeback on wb_o at %0t, two cycles after an instruction",
					$time);
				report_failure();
			end else begin
				exp_rec = exp_q.pop_front();
				check_wb(wb, exp_rec);
				n_checked++;
			end
			vld_hist = {vld_hist[0], instr_vld};
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles with %0d results checked", cycle_cnt, n_checked);
			report_failure();
		end
	end

	initial begin : stimulus
		instr_t      ins;
		logic [31:0] r;
		clk       = 1'b0;
		rst_n     = 1'b0;
		instr     = '0;
		instr_vld = 1'b0;
		rng_state = 32'h3185;
		foreach (model_regs[i])
			model_regs[i] = '0;
		foreach (recent_rd[i])
			recent_rd[i] = '0;
		repeat (8) @(posedge clk);
		#(DRIVE_DLY);
		rst_n = 1'b1;
		repeat (4) drive_idle();

		// Fresh registers read zero before the short dependent chains
		drive_instr({7'h00, 5'd3, 5'd2, 3'd0, 5'd1, 7'h33});
		drive_instr({12'd5, 5'd0, 3'd0, 5'd1, 7'h13});
		drive_instr({12'd7, 5'd1, 3'd0, 5'd1, 7'h13});
		drive_instr({12'hfff, 5'd0, 3'd0, 5'd2, 7'h13});
		drive_instr({12'd3, 5'd1, 3'd0, 5'd3, 7'h13});
		drive_instr(32'hffff_ffff);
		drive_instr({12'd1, 5'd1, 3'd0, 5'd0, 7'h13});
		drive_instr({7'h20, 5'd2, 5'd3, 3'd0, 5'd4, 7'h33});
		drive_instr({7'h00, 5'd0, 5'd4, 3'd6, 5'd5, 7'h33});

		for (int i = 0; i < N_INSTR; i++) begin
			gen_instr(ins);
			drive_instr(ins);
			next_rand(r);
			if (r[1:0] == 2'd0)
				repeat (int'(r[3:2]) + 1) drive_idle();
		end

		repeat (4) drive_idle();
		@(negedge clk);
		#(DRIVE_DLY);
		if (exp_q.size() != 0 || n_checked != n_sent) begin
			$display("Run ended with %0d of %0d results checked", n_checked, n_sent);
			report_failure();
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
rv_core_pkg.sv
rv_alu.sv
rv_regfile.sv
rv_decoder.sv
rv_execute.sv
rv_core.sv
tb_rv_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the core and its testbench with Verilator, run, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_rv_core -o Vtb_rv_core \
	&& ./obj_dir/Vtb_rv_core > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "Test OK" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
